/* src/aluDataPkg.sv */
// Data path widths for the pipelined ALU
// Real designs set the width per instance, the values here are only defaults

package aluDataPkg;

  //////////////////////////////////////////////////////////////////////
  // Width defaults
  //////////////////////////////////////////////////////////////////////

  // MIPS style word, overridable by the top level parameter
  localparam int defaultWidth = 32;

  // Operand and result word at the default width
  // Testbench side mostly, RTL uses its own width parameter
  typedef logic [defaultWidth-1:0] word;

endpackage

/* src/aluCtrlPkg.sv */
// Control code encoding of the ALU, MIPS funct style
// Code width is fixed at 4 bits, unlisted codes are flagged illegal

package aluCtrlPkg;

  //////////////////////////////////////////////////////////////////////
  // Control code type and operation codes
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0] ctrlCode;   // Fixed, not tied to data width

  // Logic unit codes
  localparam ctrlCode ctrlAnd = 4'b0000;
  localparam ctrlCode ctrlOr  = 4'b0001;
  localparam ctrlCode ctrlNor = 4'b1100;

  // Arithmetic unit codes
  localparam ctrlCode ctrlAdd = 4'b0010;
  localparam ctrlCode ctrlSub = 4'b0110;   // Inverted b plus carry in
  localparam ctrlCode ctrlSlt = 4'b0111;   // Signed compare, same adder as sub

endpackage

/* src/aluOperandIf.sv */
// Operand bundle from the top level to both execution units
// No back-pressure, fields only meaningful while valid is high

`timescale 1ns/10ps

interface aluOperandIf
#(
  parameter int width = aluDataPkg::defaultWidth
);

  logic                valid;     // Single cycle strobe
  logic [width-1:0]    a;         // First operand
  logic [width-1:0]    b;         // Second operand
  aluCtrlPkg::ctrlCode control;   // Operation select

  // Top level side
  modport source
  (
    output valid, a, b, control
  );

  // Execution unit side, shared by both units
  modport unit
  (
    input valid, a, b, control
  );

endinterface

/* src/aluUnitResultIf.sv */
// One execution unit's registered answer toward the merge stage
// Fields follow valid by zero cycles, claim marks a recognised control code

`timescale 1ns/10ps

interface aluUnitResultIf
#(
  parameter int width = aluDataPkg::defaultWidth
);

  logic             valid;      // Input strobe delayed by one clock
  logic             claim;      // Unit owns this operation
  logic [width-1:0] result;
  logic             cout;       // Carry out of top bit
  logic             overflow;   // Signed overflow

  // Unit side
  modport producer
  (
    output valid, claim, result, cout, overflow
  );

  // Merge stage side
  modport consumer
  (
    input valid, claim, result, cout, overflow
  );

endinterface

/* src/aluLogicUnit.sv */
// Bitwise AND, OR and NOR, one register stage
// Carry and overflow are never set by this unit

`timescale 1ns/10ps

module aluLogicUnit
#(
  parameter int width = aluDataPkg::defaultWidth
)
(
  input logic              clk,
  input logic              arstN,
  aluOperandIf.unit        opIn,
  aluUnitResultIf.producer resOut
);

  typedef logic [width-1:0] dataT;

  logic hit;          // Code is one of ours
  dataT nextResult;   // Bitwise answer before the register

  // Decode and compute in one go
  always_comb
  begin
    hit        = 1'b1;
    nextResult = '0;
    case (opIn.control)
      aluCtrlPkg::ctrlAnd: nextResult = opIn.a & opIn.b;
      aluCtrlPkg::ctrlOr:  nextResult = opIn.a | opIn.b;
      aluCtrlPkg::ctrlNor: nextResult = ~(opIn.a | opIn.b);
      default:             hit        = 1'b0;   // Not ours, result stays zero
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      resOut.valid  <= 1'b0;
      resOut.claim  <= 1'b0;
      resOut.result <= '0;
    end
    else
    begin
      resOut.valid <= opIn.valid;   // Strobe delayed one clock
      if (opIn.valid)               // Sample only on the strobe
      begin
        resOut.claim  <= hit;
        resOut.result <= nextResult;
      end
    end
  end

  // No carry chain here
  assign resOut.cout     = 1'b0;
  assign resOut.overflow = 1'b0;

endmodule

/* src/aluArithUnit.sv */
// ADD, SUB and signed SLT on one shared adder, one register stage
// SLT returns 0 or 1 in bit 0 and clears carry and overflow

`timescale 1ns/10ps

module aluArithUnit
#(
  parameter int width = aluDataPkg::defaultWidth
)
(
  input logic              clk,
  input logic              arstN,
  aluOperandIf.unit        opIn,
  aluUnitResultIf.producer resOut
);

  typedef logic [width-1:0] dataT;
  typedef logic [width:0]   sumT;    // Extra bit holds the carry out

  logic isAdd;
  logic isSub;
  logic isSlt;
  logic hit;
  logic invertB;       // Subtract path, also used by SLT
  dataT bOperand;      // b or its complement
  sumT  sum;
  logic sumOvf;        // Signed overflow of the raw sum
  logic lessThan;
  dataT nextResult;
  logic nextCout;
  logic nextOvf;

  // Decode
  assign isAdd   = (opIn.control == aluCtrlPkg::ctrlAdd);
  assign isSub   = (opIn.control == aluCtrlPkg::ctrlSub);
  assign isSlt   = (opIn.control == aluCtrlPkg::ctrlSlt);
  assign hit     = isAdd | isSub | isSlt;
  assign invertB = isSub | isSlt;

  //////////////////////////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////////////////////////

  assign bOperand = invertB ? ~opIn.b : opIn.b;
  assign sum      = {1'b0, opIn.a} + {1'b0, bOperand} + sumT'(invertB);   // Carry in on sub

  // Same operand signs but sum sign differs
  assign sumOvf   = (opIn.a[width-1] == bOperand[width-1]) &&
                    (sum[width-1] != opIn.a[width-1]);
  assign lessThan = sum[width-1] ^ sumOvf;   // True sign of a - b

  // Result select
  always_comb
  begin
    nextResult = '0;
    nextCout   = 1'b0;
    nextOvf    = 1'b0;
    if (isSlt)
    begin
      nextResult = {{(width-1){1'b0}}, lessThan};   // Flags stay clear
    end
    else if (isAdd || isSub)
    begin
      nextResult = sum[width-1:0];
      nextCout   = sum[width];     // For sub, 1 means no borrow
      nextOvf    = sumOvf;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      resOut.valid    <= 1'b0;
      resOut.claim    <= 1'b0;
      resOut.result   <= '0;
      resOut.cout     <= 1'b0;
      resOut.overflow <= 1'b0;
    end
    else
    begin
      resOut.valid <= opIn.valid;
      if (opIn.valid)
      begin
        resOut.claim    <= hit;
        resOut.result   <= nextResult;   // Zero when not ours
        resOut.cout     <= nextCout;
        resOut.overflow <= nextOvf;
      end
    end
  end

endmodule

/* src/aluResultMerge.sv */
// Second pipeline stage, picks the claiming unit and registers the outputs
// Relies on claim bits only, an operation claimed by no unit is illegal

`timescale 1ns/10ps

module aluResultMerge
#(
  parameter int width = aluDataPkg::defaultWidth
)
(
  input  logic             clk,
  input  logic             arstN,
  aluUnitResultIf.consumer logicRes,
  aluUnitResultIf.consumer arithRes,
  output logic             outValid,
  output logic [width-1:0] result,
  output logic             cout,
  output logic             overflow,
  output logic             zero,
  output logic             illegalOp
);

  typedef logic [width-1:0] dataT;

  logic logicHit;   // Claim qualified by the unit's strobe
  logic arithHit;
  dataT selResult;
  logic selCout;
  logic selOvf;
  logic selIllegal;

  assign logicHit = logicRes.valid & logicRes.claim;
  assign arithHit = arithRes.valid & arithRes.claim;

  // Claims are disjoint, the logic unit simply wins the tie
  always_comb
  begin
    selResult  = '0;
    selCout    = 1'b0;
    selOvf     = 1'b0;
    selIllegal = 1'b0;
    if (logicHit)
    begin
      selResult = logicRes.result;
      selCout   = logicRes.cout;
      selOvf    = logicRes.overflow;
    end
    else if (arithHit)
    begin
      selResult = arithRes.result;
      selCout   = arithRes.cout;
      selOvf    = arithRes.overflow;
    end
    else
      selIllegal = 1'b1;   // Nobody knows this code
  end

  // Output register, loads on the stage strobe only
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      outValid  <= 1'b0;
      result    <= '0;
      cout      <= 1'b0;
      overflow  <= 1'b0;
      zero      <= 1'b0;
      illegalOp <= 1'b0;
    end
    else
    begin
      outValid <= logicRes.valid;   // Two clocks after inValid
      if (logicRes.valid)
      begin
        result    <= selResult;
        cout      <= selCout;
        overflow  <= selOvf;
        zero      <= (selResult == '0);   // Also set on illegal codes
        illegalOp <= selIllegal;
      end
    end
  end

endmodule

/* src/alu32.sv */
// Two-stage ALU top, one operation per clock, result 2 clocks after inValid
// No back-pressure, width must be 2 or more

`timescale 1ns/10ps

module alu32
#(
  parameter int width = aluDataPkg::defaultWidth
)
(
  input  logic                clk,
  input  logic                arstN,
  input  logic                inValid,
  input  logic [width-1:0]    a,
  input  logic [width-1:0]    b,
  input  aluCtrlPkg::ctrlCode control,
  output logic                outValid,
  output logic [width-1:0]    result,
  output logic                cout,
  output logic                overflow,
  output logic                zero,
  output logic                illegalOp
);

  //////////////////////////////////////////////////////////////////////
  // Internal buses
  //////////////////////////////////////////////////////////////////////

  aluOperandIf    #(.width(width)) opBus ();      // Source side driven here
  aluUnitResultIf #(.width(width)) logicRes ();
  aluUnitResultIf #(.width(width)) arithRes ();

  // Operands go straight to both units, no input register
  assign opBus.valid   = inValid;
  assign opBus.a       = a;
  assign opBus.b       = b;
  assign opBus.control = control;

  //////////////////////////////////////////////////////////////////////
  // Stage 1, units side by side
  //////////////////////////////////////////////////////////////////////

  aluLogicUnit #(.width(width)) uLogic
  (
    .clk    (clk),
    .arstN  (arstN),
    .opIn   (opBus.unit),
    .resOut (logicRes.producer)
  );

  aluArithUnit #(.width(width)) uArith
  (
    .clk    (clk),
    .arstN  (arstN),
    .opIn   (opBus.unit),
    .resOut (arithRes.producer)
  );

  // Stage 2, merge and flags
  aluResultMerge #(.width(width)) uMerge
  (
    .clk       (clk),
    .arstN     (arstN),
    .logicRes  (logicRes.consumer),
    .arithRes  (arithRes.consumer),
    .outValid  (outValid),
    .result    (result),
    .cout      (cout),
    .overflow  (overflow),
    .zero      (zero),
    .illegalOp (illegalOp)
  );

endmodule

/* verif/alu32_asserts.sv */
// Strobe timing and flag rules of alu32, bound into the DUT
// Disabled while arstN is low

`timescale 1ns/10ps

module alu32_asserts
#(
  parameter int width = aluDataPkg::defaultWidth
)
(
  input logic             clk,
  input logic             arstN,
  input logic             inValid,
  input logic             outValid,
  input logic [width-1:0] result,
  input logic             zero,
  input logic             illegalOp
);

  // Strobe comes out exactly 2 clocks later
  validLatency: assert property (@(posedge clk) disable iff (!arstN)
    inValid |-> ##2 outValid)
    else $error("outValid missing 2 clocks after inValid");

  noSpuriousValid: assert property (@(posedge clk) disable iff (!arstN)
    outValid |-> $past(inValid, 2))
    else $error("outValid without inValid 2 clocks earlier");

  zeroFlag: assert property (@(posedge clk) disable iff (!arstN)
    outValid |-> (zero == (result == '0)))
    else $error("zero flag does not match result");

  illegalClears: assert property (@(posedge clk) disable iff (!arstN)
    illegalOp |-> (result == '0))   // Unknown code forces result 0
    else $error("illegalOp with nonzero result");

endmodule

/* verif/aluTb.sv */
// Directed table plus 20 random rows, all strobed back to back
// Checks stop at the first mismatch, expected values assume the default 32-bit width

`timescale 1ns/10ps

module aluTb;

  typedef aluDataPkg::word word;

  // One table row, stimulus then expected outputs
  typedef struct packed
  {
    aluCtrlPkg::ctrlCode ctrl;
    word                 a;
    word                 b;
    word                 res;
    logic                cout;
    logic                ovf;
    logic                zero;
    logic                ill;
  } rowT;

  localparam longint maxPos = 64'sh0000_0000_7fff_ffff;   // Signed 32-bit range
  localparam longint minNeg = -64'sh0000_0000_8000_0000;
  localparam int     drainLimit = 50;                      // Clocks to wait for the tail
  localparam int     pipeDepth  = 2;                       // Clocks from inValid to outValid

  logic                clk;
  logic                arstN;
  logic                inValid;
  word                 a;
  word                 b;
  aluCtrlPkg::ctrlCode control;
  logic                outValid;
  word                 result;
  logic                cout;
  logic                overflow;
  logic                zero;
  logic                illegalOp;

  rowT stimTable[$];   // Stimulus table
  rowT expQ[$];        // Operations in flight
  int  issueQ[$];      // Clock count at each strobe
  rowT expRow;
  int  issueCycle;
  int  cycleCount;
  int  waitCycles;

  alu32 dut
  (
    .clk       (clk),
    .arstN     (arstN),
    .inValid   (inValid),
    .a         (a),
    .b         (b),
    .control   (control),
    .outValid  (outValid),
    .result    (result),
    .cout      (cout),
    .overflow  (overflow),
    .zero      (zero),
    .illegalOp (illegalOp)
  );

  bind alu32 alu32_asserts #(.width(width)) uAsserts
  (
    .clk       (clk),
    .arstN     (arstN),
    .inValid   (inValid),
    .outValid  (outValid),
    .result    (result),
    .zero      (zero),
    .illegalOp (illegalOp)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // Free running clock count for latency checks
  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic checkEq(input string field, input word got, input word exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, field, got, exp);
      failRun("first mismatch reached");
    end
  endtask

  task automatic addRow(input aluCtrlPkg::ctrlCode ctrl, input word opA, input word opB,
                        input word res, input logic c, input logic o, input logic z,
                        input logic i);
    stimTable.push_back(rowT'{ctrl, opA, opB, res, c, o, z, i});
  endtask

  // Expected outputs straight from the operation rules, 64-bit math
  function automatic rowT expectFor(aluCtrlPkg::ctrlCode ctrl, word opA, word opB);
    rowT    r;
    longint sa;
    longint sb;
    longint wide;
    r      = '0;
    r.ctrl = ctrl;
    r.a    = opA;
    r.b    = opB;
    sa     = longint'($signed(opA));
    sb     = longint'($signed(opB));
    case (ctrl)
      aluCtrlPkg::ctrlAnd: r.res = opA & opB;
      aluCtrlPkg::ctrlOr:  r.res = opA | opB;
      aluCtrlPkg::ctrlNor: r.res = ~(opA | opB);
      aluCtrlPkg::ctrlAdd:
      begin
        wide   = sa + sb;
        r.res  = opA + opB;
        r.cout = (longint'(opA) + longint'(opB)) > 64'sh0000_0000_ffff_ffff;
        r.ovf  = (wide > maxPos) || (wide < minNeg);
      end
      aluCtrlPkg::ctrlSub:
      begin
        wide   = sa - sb;
        r.res  = opA - opB;
        r.cout = (opA >= opB);   // No borrow
        r.ovf  = (wide > maxPos) || (wide < minNeg);
      end
      aluCtrlPkg::ctrlSlt: r.res = (sa < sb) ? word'(1) : word'(0);
      default:             r.ill = 1'b1;
    endcase
    r.zero = (r.res == '0);
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Monitor, samples on the falling edge where outputs are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (arstN === 1'b1 && outValid === 1'b1)
    begin
      if (expQ.size() == 0)
        failRun("outValid went high with no operation in flight");
      else
      begin
        expRow     = expQ.pop_front();
        issueCycle = issueQ.pop_front();
        checkEq("latency", word'(cycleCount - issueCycle), word'(pipeDepth));
        checkEq("result", result, expRow.res);
        checkEq("cout", word'(cout), word'(expRow.cout));
        checkEq("overflow", word'(overflow), word'(expRow.ovf));
        checkEq("zero", word'(zero), word'(expRow.zero));
        checkEq("illegalOp", word'(illegalOp), word'(expRow.ill));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(93680));
    cycleCount = 0;
    arstN      = 1'b0;
    inValid    = 1'b0;
    a          = '0;
    b          = '0;
    control    = '0;

    // Logic ops
    addRow(aluCtrlPkg::ctrlAnd, 32'hffff_ffff, 32'h0f0f_00f0, 32'h0f0f_00f0, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlAnd, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0000, 0, 0, 1, 0);
    addRow(aluCtrlPkg::ctrlOr,  32'h1234_0000, 32'h0000_5678, 32'h1234_5678, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlOr,  32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 0, 0, 1, 0);
    addRow(aluCtrlPkg::ctrlNor, 32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlNor, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 0, 0, 1, 0);
    // Add and sub, carry, wrap and overflow
    addRow(aluCtrlPkg::ctrlAdd, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1, 0, 1, 0);
    addRow(aluCtrlPkg::ctrlAdd, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlAdd, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 0, 1, 0, 0);
    addRow(aluCtrlPkg::ctrlSub, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0001, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlSub, 32'h0000_0010, 32'h0000_0003, 32'h0000_000d, 1, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlSub, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1, 1, 0, 0);
    addRow(aluCtrlPkg::ctrlSub, 32'h0000_1234, 32'h0000_1234, 32'h0000_0000, 1, 0, 1, 0);
    // Signed compare
    addRow(aluCtrlPkg::ctrlSlt, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlSlt, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000, 0, 0, 1, 0);
    addRow(aluCtrlPkg::ctrlSlt, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 0, 0, 0, 0);
    addRow(aluCtrlPkg::ctrlSlt, 32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 0, 0, 1, 0);
    // Unused codes
    addRow(4'b1111, 32'h0000_dead, 32'h0000_beef, 32'h0000_0000, 0, 0, 1, 1);
    addRow(4'b0011, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 0, 0, 1, 1);

    // Random tail, includes one unused code in the mix
    for (int i = 0; i < 20; i++)
    begin
      case ($urandom % 7)
        0:       stimTable.push_back(expectFor(aluCtrlPkg::ctrlAnd, $urandom, $urandom));
        1:       stimTable.push_back(expectFor(aluCtrlPkg::ctrlOr, $urandom, $urandom));
        2:       stimTable.push_back(expectFor(aluCtrlPkg::ctrlNor, $urandom, $urandom));
        3:       stimTable.push_back(expectFor(aluCtrlPkg::ctrlAdd, $urandom, $urandom));
        4:       stimTable.push_back(expectFor(aluCtrlPkg::ctrlSub, $urandom, $urandom));
        5:       stimTable.push_back(expectFor(aluCtrlPkg::ctrlSlt, $urandom, $urandom));
        default: stimTable.push_back(expectFor(4'b1010, $urandom, $urandom));
      endcase
    end

    repeat (10) @(posedge clk);
    #1 arstN = 1'b1;

    // One row per clock, no gaps
    foreach (stimTable[i])
    begin
      @(posedge clk);
      #1;
      inValid = 1'b1;
      control = stimTable[i].ctrl;
      a       = stimTable[i].a;
      b       = stimTable[i].b;
      expQ.push_back(stimTable[i]);
      issueQ.push_back(cycleCount);
    end
    @(posedge clk);
    #1 inValid = 1'b0;

    // Drain the pipeline
    waitCycles = 0;
    while (expQ.size() != 0 && waitCycles < drainLimit)
    begin
      @(posedge clk);
      waitCycles++;
    end
    @(posedge clk);

    if (expQ.size() != 0)
      failRun("Timeout while waiting for outValid on the remaining operations");
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* verilog.f */
src/aluDataPkg.sv
src/aluCtrlPkg.sv
src/aluOperandIf.sv
src/aluUnitResultIf.sv
src/aluLogicUnit.sv
src/aluArithUnit.sv
src/aluResultMerge.sv
src/alu32.sv
verif/alu32_asserts.sv
verif/aluTb.sv

/* Bender.yml */
package:
  name: alu32

sources:
  # Packages first, then interfaces and RTL
  - files:
      - src/aluDataPkg.sv
      - src/aluCtrlPkg.sv
      - src/aluOperandIf.sv
      - src/aluUnitResultIf.sv
      - src/aluLogicUnit.sv
      - src/aluArithUnit.sv
      - src/aluResultMerge.sv
      - src/alu32.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/alu32_asserts.sv
      - verif/aluTb.sv
